// File: hw/csr_pkg.sv
////////////////////////////////////////
// register map and widths for the csr bridge; the window is 4 words at CSR_BASE.
////////////////////////////////////////
`default_nettype none

package csr_pkg;

	// host side widths.
	localparam int CSR_DATA_W = 32;
	localparam int CSR_ADDR_W = 8;
	// register index width inside the bank.
	localparam int REG_ADDR_W = 2;

	// window base, only the bits above the index are compared.
	localparam logic [CSR_ADDR_W-1:0] CSR_BASE = 8'h40;

	localparam logic [REG_ADDR_W-1:0] REG_SCRATCH = 2'd0;
	localparam logic [REG_ADDR_W-1:0] REG_CTRL    = 2'd1;
	localparam logic [REG_ADDR_W-1:0] REG_WRCOUNT = 2'd2;
	localparam logic [REG_ADDR_W-1:0] REG_VERSION = 2'd3;

	// fixed words.
	localparam logic [CSR_DATA_W-1:0] CSR_VERSION  = 32'h0001_0200;
	localparam logic [CSR_DATA_W-1:0] CSR_BAD_DATA = 32'hdead_c5a0;

	// host access sequencer states.
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RD_WAIT,
		ST_WR_WAIT
	} decode_state_e;

endpackage

`default_nettype wire

// File: hw/csr_decode.sv
////////////////////////////////////////
// one access outstanding; strobes while busy are dropped, read beats write.
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_decode (
	input  logic                                cclk,
	input  logic                                rst_b_cclk,
	input  logic                                csr_rd_strobe,
	input  logic                                csr_wr_strobe,
	input  logic [csr_pkg::CSR_ADDR_W-1:0]      csr_addr,
	input  logic [csr_pkg::CSR_DATA_W-1:0]      csr_wr_data,
	input  logic [csr_pkg::CSR_DATA_W-1:0]      rd_data_cclk,
	input  logic                                rd_done_strobe_cclk,
	input  logic                                wr_done_strobe_cclk,
	output logic [csr_pkg::CSR_DATA_W-1:0]      csr_rd_data,
	output logic                                csr_busy,
	output logic                                csr_done,
	output logic                                rd_strobe_cclk,
	output logic                                wr_strobe_cclk,
	output logic [csr_pkg::REG_ADDR_W-1:0]      reg_addr,
	output logic [csr_pkg::CSR_DATA_W-1:0]      wr_data_cclk
);

	csr_pkg::decode_state_e state;
	logic accept;
	logic mapped;

	// a strobe only counts when nothing is in flight.
	assign accept = (csr_rd_strobe || csr_wr_strobe) && !csr_busy;
	// upper address bits select the window.
	assign mapped = csr_addr[csr_pkg::CSR_ADDR_W-1:csr_pkg::REG_ADDR_W] ==
		csr_pkg::CSR_BASE[csr_pkg::CSR_ADDR_W-1:csr_pkg::REG_ADDR_W];
	// busy covers the wait states and the done cycle itself.
	assign csr_busy = (state != csr_pkg::ST_IDLE) || csr_done;

	always_ff @(posedge cclk) begin
		if (!rst_b_cclk) begin
			state <= csr_pkg::ST_IDLE;
			csr_done <= 1'b0;
			rd_strobe_cclk <= 1'b0;
			wr_strobe_cclk <= 1'b0;
		end else begin
			// pulses default low.
			csr_done <= 1'b0;
			rd_strobe_cclk <= 1'b0;
			wr_strobe_cclk <= 1'b0;
			case (state)
				csr_pkg::ST_IDLE: begin
					if (accept && !mapped) begin
						// unmapped, complete next cycle.
						csr_done <= 1'b1;
					end else if (accept && csr_rd_strobe) begin
						state <= csr_pkg::ST_RD_WAIT;
						rd_strobe_cclk <= 1'b1;
					end else if (accept) begin
						state <= csr_pkg::ST_WR_WAIT;
						wr_strobe_cclk <= 1'b1;
					end
				end
				csr_pkg::ST_RD_WAIT: begin
					if (rd_done_strobe_cclk) begin
						state <= csr_pkg::ST_IDLE;
						csr_done <= 1'b1;
					end
				end
				csr_pkg::ST_WR_WAIT: begin
					if (wr_done_strobe_cclk) begin
						state <= csr_pkg::ST_IDLE;
						csr_done <= 1'b1;
					end
				end
				default: state <= csr_pkg::ST_IDLE;
			endcase
		end
	end

	// index and data held steady until the crossing is done.
	always_ff @(posedge cclk) begin
		if (accept && mapped) begin
			reg_addr <= csr_addr[csr_pkg::REG_ADDR_W-1:0];
			wr_data_cclk <= csr_wr_data;
		end
	end

	// response register, holds until the next read ends.
	always_ff @(posedge cclk) begin
		if (accept && !mapped && csr_rd_strobe)
			csr_rd_data <= csr_pkg::CSR_BAD_DATA;
		else if (state == csr_pkg::ST_RD_WAIT && rd_done_strobe_cclk)
			csr_rd_data <= rd_data_cclk;
	end

endmodule

`default_nettype wire

// File: hw/csr_async_read.sv
////////////////////////////////////////
// clocks may be unrelated; data bus skew must stay under one tclk cycle.
// rd_data_tclk must be stable while the request toggle crosses.
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_async_read #(
	parameter int WIDTH = 32
) (
	input  logic             cclk,
	input  logic             tclk,
	input  logic             rst_b_cclk,
	input  logic             rst_b_tclk,
	input  logic             rd_strobe_cclk,
	input  logic [WIDTH-1:0] rd_data_tclk,
	output logic [WIDTH-1:0] rd_data_cclk,
	output logic             rd_wait_cclk,
	output logic             rd_done_strobe_cclk,
	output logic             rd_strobe_tclk
);

	// request toggle owned by cclk.
	logic req_cclk;
	// acknowledge toggle owned by tclk.
	logic ack_tclk;
	// request seen in tclk.
	logic req_s1_tclk;
	logic req_s2_tclk;
	// acknowledge seen in cclk, plus one settle stage.
	logic ack_s1_cclk;
	logic ack_s2_cclk;
	logic ack_s3_cclk;
	logic rd_wait_d_cclk;
	// latched target word and its cclk sync stage.
	logic [WIDTH-1:0] data_l_tclk;
	logic [WIDTH-1:0] data_s1_cclk;

	always_ff @(posedge cclk) begin
		if (!rst_b_cclk) begin
			req_cclk <= 1'b0;
			ack_s1_cclk <= 1'b0;
			ack_s2_cclk <= 1'b0;
			ack_s3_cclk <= 1'b0;
			rd_wait_d_cclk <= 1'b0;
		end else begin
			if (rd_strobe_cclk)
				req_cclk <= ~req_cclk;
			ack_s1_cclk <= ack_tclk;
			ack_s2_cclk <= ack_s1_cclk;
			// extra stage so the data sync below has caught up.
			ack_s3_cclk <= ack_s2_cclk;
			rd_wait_d_cclk <= rd_wait_cclk;
		end
	end

	// data bus crosses on its own, it is static by the time ack lands.
	always_ff @(posedge cclk) begin
		data_s1_cclk <= data_l_tclk;
		rd_data_cclk <= data_s1_cclk;
	end

	// wait rises with the strobe and clears once the toggles agree.
	assign rd_wait_cclk = rd_strobe_cclk || (req_cclk != ack_s3_cclk);
	// done marks wait falling.
	assign rd_done_strobe_cclk = !rd_wait_cclk && rd_wait_d_cclk;

	always_ff @(posedge tclk) begin
		if (!rst_b_tclk) begin
			req_s1_tclk <= 1'b0;
			req_s2_tclk <= 1'b0;
			ack_tclk <= 1'b0;
			rd_strobe_tclk <= 1'b0;
		end else begin
			req_s1_tclk <= req_cclk;
			req_s2_tclk <= req_s1_tclk;
			// new request: answer it and flag the read a cycle later.
			rd_strobe_tclk <= req_s2_tclk != ack_tclk;
			ack_tclk <= req_s2_tclk;
		end
	end

	// target word captured on the toggle change.
	always_ff @(posedge tclk) begin
		if (req_s2_tclk != ack_tclk)
			data_l_tclk <= rd_data_tclk;
	end

endmodule

`default_nettype wire

// File: hw/csr_async_write.sv
////////////////////////////////////////
// address and data must be held in cclk until wr_done_strobe_cclk.
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_async_write #(
	parameter int WIDTH = 32
) (
	input  logic                            cclk,
	input  logic                            tclk,
	input  logic                            rst_b_cclk,
	input  logic                            rst_b_tclk,
	input  logic                            wr_strobe_cclk,
	input  logic [csr_pkg::REG_ADDR_W-1:0]  wr_addr_cclk,
	input  logic [WIDTH-1:0]                wr_data_cclk,
	output logic                            wr_wait_cclk,
	output logic                            wr_done_strobe_cclk,
	output logic                            wr_strobe_tclk,
	output logic [csr_pkg::REG_ADDR_W-1:0]  wr_addr_tclk,
	output logic [WIDTH-1:0]                wr_data_tclk
);

	// request toggle, flips once per write.
	logic req_cclk;
	// tclk copy of the last serviced request.
	logic ack_tclk;
	// two flop sync of the request.
	logic req_s1_tclk;
	logic req_s2_tclk;
	// two flop sync of the acknowledge.
	logic ack_s1_cclk;
	logic ack_s2_cclk;
	logic wr_wait_d_cclk;
	logic req_new_tclk;

	always_ff @(posedge cclk) begin
		if (!rst_b_cclk) begin
			req_cclk <= 1'b0;
			ack_s1_cclk <= 1'b0;
			ack_s2_cclk <= 1'b0;
			wr_wait_d_cclk <= 1'b0;
		end else begin
			if (wr_strobe_cclk)
				req_cclk <= ~req_cclk;
			ack_s1_cclk <= ack_tclk;
			ack_s2_cclk <= ack_s1_cclk;
			wr_wait_d_cclk <= wr_wait_cclk;
		end
	end

	// held until the acknowledge comes home.
	assign wr_wait_cclk = wr_strobe_cclk || (req_cclk != ack_s2_cclk);
	assign wr_done_strobe_cclk = !wr_wait_cclk && wr_wait_d_cclk;

	// synchronized toggle differs from the serviced one.
	assign req_new_tclk = req_s2_tclk != ack_tclk;

	always_ff @(posedge tclk) begin
		if (!rst_b_tclk) begin
			req_s1_tclk <= 1'b0;
			req_s2_tclk <= 1'b0;
			ack_tclk <= 1'b0;
			wr_strobe_tclk <= 1'b0;
		end else begin
			req_s1_tclk <= req_cclk;
			req_s2_tclk <= req_s1_tclk;
			ack_tclk <= req_s2_tclk;
			// third tclk edge after the toggle.
			wr_strobe_tclk <= req_new_tclk;
		end
	end

	// quasi-static bus, sampled once the toggle is through.
	always_ff @(posedge tclk) begin
		if (req_new_tclk) begin
			wr_addr_tclk <= wr_addr_cclk;
			wr_data_tclk <= wr_data_cclk;
		end
	end

endmodule

`default_nettype wire

// File: hw/csr_target_regs.sv
////////////////////////////////////////
// counter counts every write strobe; read mux is combinational on reg_addr.
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_target_regs (
	input  logic                            tclk,
	input  logic                            rst_b_tclk,
	input  logic [csr_pkg::REG_ADDR_W-1:0]  reg_addr,
	input  logic                            rd_strobe_tclk,
	input  logic                            wr_strobe_tclk,
	input  logic [csr_pkg::REG_ADDR_W-1:0]  wr_addr_tclk,
	input  logic [csr_pkg::CSR_DATA_W-1:0]  wr_data_tclk,
	output logic [csr_pkg::CSR_DATA_W-1:0]  rd_data_tclk
);

	logic [csr_pkg::CSR_DATA_W-1:0] scratch;
	logic [csr_pkg::CSR_DATA_W-1:0] ctrl;
	logic [csr_pkg::CSR_DATA_W-1:0] wr_count;
	logic count_clear;

	// read side effect only, index comes from reg_addr.
	assign count_clear = rd_strobe_tclk && (reg_addr == csr_pkg::REG_WRCOUNT);

	// write decode.
	always_ff @(posedge tclk) begin
		if (!rst_b_tclk) begin
			scratch <= '0;
			ctrl <= '0;
		end else if (wr_strobe_tclk) begin
			if (wr_addr_tclk == csr_pkg::REG_SCRATCH)
				scratch <= wr_data_tclk;
			if (wr_addr_tclk == csr_pkg::REG_CTRL)
				ctrl <= wr_data_tclk;
		end
	end

	// write counter, clear and write together leave 1.
	always_ff @(posedge tclk) begin
		if (!rst_b_tclk)
			wr_count <= '0;
		else if (count_clear && wr_strobe_tclk)
			wr_count <= 32'd1;
		else if (count_clear)
			wr_count <= '0;
		else if (wr_strobe_tclk)
			// wraps at full width.
			wr_count <= wr_count + 32'd1;
	end

	// read mux.
	always_comb begin
		case (reg_addr)
			csr_pkg::REG_SCRATCH: rd_data_tclk = scratch;
			csr_pkg::REG_CTRL:    rd_data_tclk = ctrl;
			csr_pkg::REG_WRCOUNT: rd_data_tclk = wr_count;
			default:              rd_data_tclk = csr_pkg::CSR_VERSION;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/csr_bridge_top.sv
////////////////////////////////////////
// separate synchronous resets per domain, no reset sync inside.
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_bridge_top (
	input  logic                            cclk,
	input  logic                            tclk,
	input  logic                            rst_b_cclk,
	input  logic                            rst_b_tclk,
	input  logic                            csr_rd_strobe,
	input  logic                            csr_wr_strobe,
	input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_addr,
	input  logic [csr_pkg::CSR_DATA_W-1:0]  csr_wr_data,
	output logic [csr_pkg::CSR_DATA_W-1:0]  csr_rd_data,
	output logic                            csr_busy,
	output logic                            csr_done
);

	// cclk side.
	logic                           rd_strobe_cclk;
	logic                           wr_strobe_cclk;
	logic                           rd_done_strobe_cclk;
	logic                           wr_done_strobe_cclk;
	logic [csr_pkg::REG_ADDR_W-1:0] reg_addr;
	logic [csr_pkg::CSR_DATA_W-1:0] rd_data_cclk;
	logic [csr_pkg::CSR_DATA_W-1:0] wr_data_cclk;
	// tclk side.
	logic                           rd_strobe_tclk;
	logic                           wr_strobe_tclk;
	logic [csr_pkg::REG_ADDR_W-1:0] wr_addr_tclk;
	logic [csr_pkg::CSR_DATA_W-1:0] rd_data_tclk;
	logic [csr_pkg::CSR_DATA_W-1:0] wr_data_tclk;

	csr_decode i_csr_decode (
		.cclk(cclk), .rst_b_cclk(rst_b_cclk),
		.csr_rd_strobe(csr_rd_strobe), .csr_wr_strobe(csr_wr_strobe),
		.csr_addr(csr_addr), .csr_wr_data(csr_wr_data),
		.rd_data_cclk(rd_data_cclk), .rd_done_strobe_cclk(rd_done_strobe_cclk),
		.wr_done_strobe_cclk(wr_done_strobe_cclk), .csr_rd_data(csr_rd_data),
		.csr_busy(csr_busy), .csr_done(csr_done), .rd_strobe_cclk(rd_strobe_cclk),
		.wr_strobe_cclk(wr_strobe_cclk), .reg_addr(reg_addr), .wr_data_cclk(wr_data_cclk)
	);

	// wait levels are only used inside the crossings.
	csr_async_read #(.WIDTH(csr_pkg::CSR_DATA_W)) i_csr_async_read (
		.cclk(cclk), .tclk(tclk), .rst_b_cclk(rst_b_cclk), .rst_b_tclk(rst_b_tclk),
		.rd_strobe_cclk(rd_strobe_cclk), .rd_data_tclk(rd_data_tclk),
		.rd_data_cclk(rd_data_cclk), .rd_wait_cclk(),
		.rd_done_strobe_cclk(rd_done_strobe_cclk), .rd_strobe_tclk(rd_strobe_tclk)
	);

	csr_async_write #(.WIDTH(csr_pkg::CSR_DATA_W)) i_csr_async_write (
		.cclk(cclk), .tclk(tclk), .rst_b_cclk(rst_b_cclk), .rst_b_tclk(rst_b_tclk),
		.wr_strobe_cclk(wr_strobe_cclk), .wr_addr_cclk(reg_addr),
		.wr_data_cclk(wr_data_cclk), .wr_wait_cclk(),
		.wr_done_strobe_cclk(wr_done_strobe_cclk), .wr_strobe_tclk(wr_strobe_tclk),
		.wr_addr_tclk(wr_addr_tclk), .wr_data_tclk(wr_data_tclk)
	);

	csr_target_regs i_csr_target_regs (
		.tclk(tclk), .rst_b_tclk(rst_b_tclk), .reg_addr(reg_addr),
		.rd_strobe_tclk(rd_strobe_tclk), .wr_strobe_tclk(wr_strobe_tclk),
		.wr_addr_tclk(wr_addr_tclk), .wr_data_tclk(wr_data_tclk),
		.rd_data_tclk(rd_data_tclk)
	);

endmodule

`default_nettype wire

// File: sim/tb_csr_bridge.sv
////////////////////////////////////////
// one host access at a time; cclk 8 ns, tclk 13 ns.
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_csr_bridge;

	localparam int NUM_ACCESSES = 300;
	localparam int CYCLE_LIMIT = NUM_ACCESSES * 60 + 200;

	logic cclk = 1'b0;
	logic tclk = 1'b0;
	logic rst_b_cclk = 1'b0;
	logic rst_b_tclk = 1'b0;
	logic csr_rd_strobe = 1'b0;
	logic csr_wr_strobe = 1'b0;
	logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr = '0;
	logic [csr_pkg::CSR_DATA_W-1:0] csr_wr_data = '0;
	logic [csr_pkg::CSR_DATA_W-1:0] csr_rd_data;
	logic csr_busy;
	logic csr_done;

	// reference model state.
	logic [csr_pkg::CSR_DATA_W-1:0] m_scratch = '0;
	logic [csr_pkg::CSR_DATA_W-1:0] m_ctrl = '0;
	logic [csr_pkg::CSR_DATA_W-1:0] m_count = '0;
	integer seed = 32'h60bee229;
	int checks = 0;
	int errors = 0;
	int test_start_errors = 0;
	int cycles = 0;

	// the two clocks share no ratio, so the phase drifts.
	always #4 cclk = ~cclk;
	always #6.5 tclk = ~tclk;

	csr_bridge_top i_csr_bridge_top (
		.cclk(cclk), .tclk(tclk), .rst_b_cclk(rst_b_cclk), .rst_b_tclk(rst_b_tclk),
		.csr_rd_strobe(csr_rd_strobe), .csr_wr_strobe(csr_wr_strobe),
		.csr_addr(csr_addr), .csr_wr_data(csr_wr_data), .csr_rd_data(csr_rd_data),
		.csr_busy(csr_busy), .csr_done(csr_done)
	);

	// watchdog on the whole run.
	always @(posedge cclk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cclk cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	// window hit when the bits above the index match the base.
	function automatic logic is_mapped(input logic [csr_pkg::CSR_ADDR_W-1:0] addr);
		return addr[csr_pkg::CSR_ADDR_W-1:csr_pkg::REG_ADDR_W] ==
			csr_pkg::CSR_BASE[csr_pkg::CSR_ADDR_W-1:csr_pkg::REG_ADDR_W];
	endfunction

	function automatic logic [csr_pkg::CSR_ADDR_W-1:0] map_addr(
		input logic [csr_pkg::REG_ADDR_W-1:0] idx);
		return {csr_pkg::CSR_BASE[csr_pkg::CSR_ADDR_W-1:csr_pkg::REG_ADDR_W], idx};
	endfunction

	// model write, any mapped write counts, version ignores the data.
	function automatic void model_write(input logic [csr_pkg::CSR_ADDR_W-1:0] addr,
		input logic [csr_pkg::CSR_DATA_W-1:0] data);
		if (is_mapped(addr)) begin
			if (addr[1:0] == 2'd0)
				m_scratch = data;
			else if (addr[1:0] == 2'd1)
				m_ctrl = data;
			m_count = m_count + 32'd1;
		end
	endfunction

	// model read, the count clears once it is read.
	function automatic logic [csr_pkg::CSR_DATA_W-1:0] model_read(
		input logic [csr_pkg::CSR_ADDR_W-1:0] addr);
		logic [csr_pkg::CSR_DATA_W-1:0] val;
		if (!is_mapped(addr))
			return 32'hdead_c5a0;
		case (addr[1:0])
			2'd0: val = m_scratch;
			2'd1: val = m_ctrl;
			2'd2: begin
				val = m_count;
				m_count = '0;
			end
			default: val = 32'h0001_0200;
		endcase
		return val;
	endfunction

	task automatic check_data(input string name, input logic [csr_pkg::CSR_DATA_W-1:0] exp,
		input logic [csr_pkg::CSR_DATA_W-1:0] act);
		checks = checks + 1;
		if (act !== exp) begin
			errors = errors + 1;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		checks = checks + 1;
		if (act != exp) begin
			errors = errors + 1;
			$display("Fail %s: expected %0d cycles, actual %0d cycles", name, exp, act);
		end
	endtask

	task automatic check_idle(input string name);
		checks = checks + 1;
		if (csr_busy !== 1'b0 || csr_done !== 1'b0) begin
			errors = errors + 1;
			$display("%s: busy or done is high while no access is in flight", name);
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == test_start_errors)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// called on a falling edge; returns one edge after done, when busy is low.
	task automatic run_access(input logic rd, input logic wr,
		input logic [csr_pkg::CSR_ADDR_W-1:0] addr, input logic [csr_pkg::CSR_DATA_W-1:0] data,
		output logic [csr_pkg::CSR_DATA_W-1:0] rdata, output int lat);
		csr_rd_strobe = rd;
		csr_wr_strobe = wr;
		csr_addr = addr;
		csr_wr_data = data;
		@(negedge cclk);
		csr_rd_strobe = 1'b0;
		csr_wr_strobe = 1'b0;
		lat = 1;
		while (csr_done !== 1'b1) begin
			@(negedge cclk);
			lat = lat + 1;
		end
		rdata = csr_rd_data;
		@(negedge cclk);
	endtask

	task automatic write_reg(input logic [csr_pkg::CSR_ADDR_W-1:0] addr,
		input logic [csr_pkg::CSR_DATA_W-1:0] data);
		logic [csr_pkg::CSR_DATA_W-1:0] rdata;
		int lat;
		run_access(1'b0, 1'b1, addr, data, rdata, lat);
		model_write(addr, data);
	endtask

	task automatic read_reg(input string name, input logic [csr_pkg::CSR_ADDR_W-1:0] addr);
		logic [csr_pkg::CSR_DATA_W-1:0] exp;
		logic [csr_pkg::CSR_DATA_W-1:0] rdata;
		int lat;
		exp = model_read(addr);
		run_access(1'b1, 1'b0, addr, '0, rdata, lat);
		check_data(name, exp, rdata);
	endtask

	task automatic pick_unmapped(output logic [csr_pkg::CSR_ADDR_W-1:0] addr);
		logic [31:0] r;
		r = $random(seed);
		addr = r[csr_pkg::CSR_ADDR_W-1:0];
		while (is_mapped(addr)) begin
			r = $random(seed);
			addr = r[csr_pkg::CSR_ADDR_W-1:0];
		end
	endtask

	initial begin
		logic [31:0] rnd;
		logic [csr_pkg::CSR_ADDR_W-1:0] addr;
		logic [csr_pkg::CSR_DATA_W-1:0] data;
		logic [csr_pkg::CSR_DATA_W-1:0] rdata;
		int lat;
		int nwr;

		repeat (10) @(negedge cclk);
		rst_b_cclk = 1'b1;
		rst_b_tclk = 1'b1;

		// quiet after reset, then the version word.
		repeat (5) begin
			@(negedge cclk);
			check_idle("reset_idle");
		end
		read_reg("reset_version", map_addr(2'd3));
		finish_test("reset_version");

		// scratch and ctrl hold the last written value.
		for (int i = 0; i < 20; i++) begin
			rnd = $random(seed);
			addr = map_addr({1'b0, rnd[0]});
			write_reg(addr, $random(seed));
			read_reg("rw_scratch_ctrl", addr);
		end
		finish_test("rw_scratch_ctrl");

		// count since the last read, version writes count too.
		read_reg("wrcount_clear", map_addr(2'd2));
		rnd = $random(seed);
		nwr = 1 + int'(rnd[2:0]);
		for (int i = 0; i < nwr; i++) begin
			rnd = $random(seed);
			write_reg(map_addr(rnd[1:0]), $random(seed));
		end
		// one write to version on top.
		write_reg(map_addr(2'd3), $random(seed));
		nwr = nwr + 1;
		void'(model_read(map_addr(2'd2)));
		run_access(1'b1, 1'b0, map_addr(2'd2), '0, rdata, lat);
		check_data("wrcount_value", 32'(nwr), rdata);
		read_reg("wrcount_reread", map_addr(2'd2));
		read_reg("wrcount_version", map_addr(2'd3));
		finish_test("wrcount");

		// unmapped read returns the fixed word one cycle after the strobe.
		pick_unmapped(addr);
		run_access(1'b1, 1'b0, addr, '0, rdata, lat);
		check_data("unmapped_read", 32'hdead_c5a0, rdata);
		check_latency("unmapped_read_latency", 1, lat);
		check_idle("unmapped_read_idle");
		pick_unmapped(addr);
		run_access(1'b0, 1'b1, addr, $random(seed), rdata, lat);
		check_latency("unmapped_write_latency", 1, lat);
		read_reg("unmapped_scratch", map_addr(2'd0));
		read_reg("unmapped_ctrl", map_addr(2'd1));
		read_reg("unmapped_wrcount", map_addr(2'd2));
		finish_test("unmapped");

		// strobes during a write in flight are dropped.
		data = $random(seed);
		csr_wr_strobe = 1'b1;
		csr_addr = map_addr(2'd0);
		csr_wr_data = data;
		@(negedge cclk);
		csr_wr_strobe = 1'b0;
		@(negedge cclk);
		checks = checks + 1;
		if (csr_busy !== 1'b1) begin
			errors = errors + 1;
			$display("busy_drop: busy is low while a mapped write is in flight");
		end
		csr_rd_strobe = 1'b1;
		csr_wr_strobe = 1'b1;
		csr_addr = map_addr(2'd1);
		csr_wr_data = ~data;
		@(negedge cclk);
		csr_rd_strobe = 1'b0;
		csr_wr_strobe = 1'b0;
		while (csr_done !== 1'b1)
			@(negedge cclk);
		// the done cycle still counts as busy.
		csr_wr_strobe = 1'b1;
		@(negedge cclk);
		csr_wr_strobe = 1'b0;
		model_write(map_addr(2'd0), data);
		check_idle("busy_drop_idle");
		read_reg("busy_drop_scratch", map_addr(2'd0));
		read_reg("busy_drop_ctrl", map_addr(2'd1));
		// both strobes at once, only the read happens.
		data = model_read(map_addr(2'd1));
		run_access(1'b1, 1'b1, map_addr(2'd1), $random(seed), rdata, lat);
		check_data("both_strobes_read", data, rdata);
		read_reg("both_strobes_ctrl", map_addr(2'd1));
		read_reg("both_strobes_wrcount", map_addr(2'd2));
		finish_test("busy_and_both");

		// long random mix over the map and outside it.
		for (int i = 0; i < 200; i++) begin
			rnd = $random(seed);
			if (rnd[3:1] == 3'd0)
				pick_unmapped(addr);
			else
				addr = map_addr(rnd[5:4]);
			if (rnd[0])
				read_reg("random_mix", addr);
			else
				write_reg(addr, $random(seed));
		end
		finish_test("random_mix");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_async_read.sv
hw/csr_async_write.sv
hw/csr_target_regs.sv
hw/csr_bridge_top.sv
sim/tb_csr_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build the CSR bridge testbench with Verilator, run it, then look for the pass line in the log.
verilator --binary --timing --timescale 1ns/100ps -f files.f \
	--top-module tb_csr_bridge -Mdir obj_dir -o sim_csr_bridge > build.log 2>&1 &&
	./obj_dir/sim_csr_bridge > sim.log 2>&1 &&
	grep -q "^Done: no errors$" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }
